// File: logic/bp_macros.svh
// predictor sizes; index and tag bits must fit in the pc above the two byte-offset bits
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// address width
`define BP_XLEN 32

// byte offset below the index, word aligned pcs only
`define BP_OFFSET_BITS 2

// pc index bits, 16 entries per table
`define BP_INDEX_BITS 4

// local history length per entry
`define BP_HIST_BITS 2

// tag bits taken just above the index
`define BP_TAG_BITS 6

`endif

// File: logic/bp_pkg.sv
// shared types for the predictor; field widths follow bp_macros.svh and pcs are word aligned
`include "bp_macros.svh"

package bp_pkg;

    // full byte address
    typedef logic [`BP_XLEN-1:0] pc_t;

    // word address as stored in the btb
    typedef logic [`BP_XLEN-`BP_OFFSET_BITS-1:0] word_t;

    // table index taken from the pc
    typedef logic [`BP_INDEX_BITS-1:0] index_t;

    // newest outcome sits in bit 0
    typedef logic [`BP_HIST_BITS-1:0] hist_t;

    // btb tag
    typedef logic [`BP_TAG_BITS-1:0] tag_t;

    // pattern table index is pc index then history
    typedef logic [`BP_INDEX_BITS+`BP_HIST_BITS-1:0] ctr_index_t;

    // two-bit saturating counter states
    typedef enum logic [1:0] {
        nt_strong = 2'b00,
        nt_weak   = 2'b01,
        t_weak    = 2'b10,
        t_strong  = 2'b11
    } ctr_state_t;

    // 38 bit btb entry
    typedef struct packed {
        logic  valid;
        logic  uncond;
        tag_t  tag;
        word_t target;
    } btb_entry_t;

    function automatic index_t pc_index(pc_t pc);
        return pc[`BP_OFFSET_BITS +: `BP_INDEX_BITS];
    endfunction

    function automatic tag_t pc_tag(pc_t pc);
        return pc[`BP_OFFSET_BITS+`BP_INDEX_BITS +: `BP_TAG_BITS];
    endfunction

    function automatic word_t pc_word(pc_t pc);
        return pc[`BP_XLEN-1:`BP_OFFSET_BITS];
    endfunction

endpackage

// File: logic/bp_update_if.sv
// one resolved branch per cycle from execute; no back-pressure, every valid cycle is taken
`timescale 1ns/1ps

interface bp_update_if
    import bp_pkg::*;
();

    // update strobe
    logic valid;
    // branch was conditional
    logic cond;
    // branch pc
    pc_t  pc;
    // resolved direction
    logic taken;
    // resolved target
    pc_t  target;

    // driven from the top level ports
    modport source (output valid, output cond, output pc, output taken, output target);

    // read by the history, counter and target units
    modport sink (input valid, input cond, input pc, input taken, input target);

endinterface

// File: logic/pred_table.sv
// direct-mapped table; depth is 2 to the width of index_t, reads are combinational
`timescale 1ns/1ps

module pred_table #(
    parameter type    entry_t     = logic,
    parameter type    index_t     = logic,
    parameter entry_t reset_value = '0
) (
    input  logic   clock,
    input  logic   reset,
    // fetch side lookup
    input  index_t read_index,
    output entry_t read_entry,
    // execute side read of the entry being updated
    input  index_t update_index,
    output entry_t update_entry,
    // single write port
    input  logic   write,
    input  index_t write_index,
    input  entry_t write_entry
);

    localparam int depth = 2 ** $bits(index_t);

    entry_t entries [depth];

    //////////////////////////////
    // read ports
    //////////////////////////////

    // lookup sees the state from before this cycle's write
    assign read_entry   = entries[read_index];
    assign update_entry = entries[update_index];

    //////////////////////////////
    // write port
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            // every entry back to the table's own reset value
            for (int i = 0; i < depth; i++) begin
                entries[i] <= reset_value;
            end
        end else if (write) begin
            entries[write_index] <= write_entry;
        end
    end

endmodule

// File: logic/history_unit.sv
// local history per pc index, no tag check; only conditional branches shift in an outcome
`timescale 1ns/1ps

module history_unit
    import bp_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  pc_t              lookup_pc,
    bp_update_if.sink        update,
    output hist_t            lookup_hist,
    output hist_t            update_hist
);

    index_t lookup_index;
    index_t update_index;
    logic   shift;
    hist_t  shifted_hist;

    //////////////////////////////
    // index and shift
    //////////////////////////////

    assign lookup_index = pc_index(lookup_pc);
    assign update_index = pc_index(update.pc);

    // unconditional branches leave the history alone
    assign shift = update.valid && update.cond;

    // drop the oldest bit, newest outcome lands in bit 0
    assign shifted_hist = hist_t'({update_hist, update.taken});

    //////////////////////////////
    // history table
    //////////////////////////////

    // update read doubles as the counter index history
    pred_table #(
        .entry_t     (hist_t),
        .index_t     (index_t),
        .reset_value ('0)
    ) u_hist_table (
        .clock        (clock),
        .reset        (reset),
        .read_index   (lookup_index),
        .read_entry   (lookup_hist),
        .update_index (update_index),
        .update_entry (update_hist),
        .write        (shift),
        .write_index  (update_index),
        .write_entry  (shifted_hist)
    );

endmodule

// File: logic/counter_unit.sv
// pattern table of two-bit counters; update_hist must be the pre-shift history of update.pc
`timescale 1ns/1ps

module counter_unit
    import bp_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  pc_t              lookup_pc,
    input  hist_t            lookup_hist,
    input  hist_t            update_hist,
    bp_update_if.sink        update,
    output logic             counter_taken
);

    ctr_index_t lookup_index;
    ctr_index_t update_index;
    ctr_state_t lookup_state;
    ctr_state_t update_state;
    ctr_state_t next_state;
    logic       train;

    //////////////////////////////
    // indexing
    //////////////////////////////

    // pc index in the high bits, local history in the low bits
    assign lookup_index = {pc_index(lookup_pc), lookup_hist};
    assign update_index = {pc_index(update.pc), update_hist};

    // only conditional branches train
    assign train = update.valid && update.cond;

    //////////////////////////////
    // state transition
    //////////////////////////////

    always_comb begin
        case (update_state)
            nt_strong: begin
                next_state = update.taken ? nt_weak : nt_strong;
            end
            nt_weak: begin
                // one taken outcome jumps straight to strong
                next_state = update.taken ? t_strong : nt_strong;
            end
            t_weak: begin
                next_state = update.taken ? t_strong : nt_strong;
            end
            t_strong: begin
                next_state = update.taken ? t_strong : t_weak;
            end
        endcase
    end

    //////////////////////////////
    // counter table
    //////////////////////////////

    // every counter starts weakly not taken
    pred_table #(
        .entry_t     (ctr_state_t),
        .index_t     (ctr_index_t),
        .reset_value (nt_weak)
    ) u_ctr_table (
        .clock        (clock),
        .reset        (reset),
        .read_index   (lookup_index),
        .read_entry   (lookup_state),
        .update_index (update_index),
        .update_entry (update_state),
        .write        (train),
        .write_index  (update_index),
        .write_entry  (next_state)
    );

    // upper half of the counter range predicts taken
    assign counter_taken = (lookup_state == t_weak) || (lookup_state == t_strong);

endmodule

// File: logic/target_unit.sv
// direct-mapped btb with full word targets; a later branch at the same index evicts the entry
`timescale 1ns/1ps

module target_unit
    import bp_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  pc_t              lookup_pc,
    bp_update_if.sink        update,
    output logic             hit,
    output logic             uncond,
    output pc_t              target
);

    index_t     lookup_index;
    index_t     write_index;
    btb_entry_t lookup_entry;
    btb_entry_t new_entry;

    //////////////////////////////
    // write side
    //////////////////////////////

    assign lookup_index = pc_index(lookup_pc);
    assign write_index  = pc_index(update.pc);

    // any resolved branch allocates, conditional or not
    always_comb begin
        new_entry.valid  = 1'b1;
        new_entry.uncond = !update.cond;
        new_entry.tag    = pc_tag(update.pc);
        new_entry.target = pc_word(update.target);
    end

    //////////////////////////////
    // entry storage
    //////////////////////////////

    // reset clears the valid bits along with everything else
    pred_table #(
        .entry_t     (btb_entry_t),
        .index_t     (index_t),
        .reset_value ('0)
    ) u_btb_table (
        .clock        (clock),
        .reset        (reset),
        .read_index   (lookup_index),
        .read_entry   (lookup_entry),
        .update_index (write_index),
        .update_entry (),
        .write        (update.valid),
        .write_index  (write_index),
        .write_entry  (new_entry)
    );

    //////////////////////////////
    // lookup result
    //////////////////////////////

    // aliased pcs with another tag miss
    assign hit    = lookup_entry.valid && (lookup_entry.tag == pc_tag(lookup_pc));
    assign uncond = lookup_entry.uncond;

    // rebuild byte address from the stored word
    assign target = {lookup_entry.target, 2'b00};

endmodule

// File: logic/branch_predictor.sv
// single-issue predictor; lookup is combinational, an update shows from the next cycle on
`timescale 1ns/1ps

module branch_predictor
    import bp_pkg::*;
(
    input  logic clock,
    input  logic reset,
    // fetch side
    input  pc_t  lookup_pc,
    // resolved branch from execute
    input  logic update_valid,
    input  logic update_cond,
    input  pc_t  update_pc,
    input  logic update_taken,
    input  pc_t  update_target,
    // prediction
    output logic predict_hit,
    output logic predict_taken,
    output pc_t  next_pc
);

    hist_t lookup_hist;
    hist_t update_hist;
    logic  counter_taken;
    logic  target_hit;
    logic  target_uncond;
    pc_t   target_pc;
    pc_t   fall_through;

    //////////////////////////////
    // update bundle
    //////////////////////////////

    bp_update_if u_update ();

    // plain ports fan out to the three units
    assign u_update.valid  = update_valid;
    assign u_update.cond   = update_cond;
    assign u_update.pc     = update_pc;
    assign u_update.taken  = update_taken;
    assign u_update.target = update_target;

    //////////////////////////////
    // units
    //////////////////////////////

    history_unit u_history (
        .clock       (clock),
        .reset       (reset),
        .lookup_pc   (lookup_pc),
        .update      (u_update),
        .lookup_hist (lookup_hist),
        .update_hist (update_hist)
    );

    // counter trains under the history from before the shift
    counter_unit u_counter (
        .clock         (clock),
        .reset         (reset),
        .lookup_pc     (lookup_pc),
        .lookup_hist   (lookup_hist),
        .update_hist   (update_hist),
        .update        (u_update),
        .counter_taken (counter_taken)
    );

    target_unit u_target (
        .clock     (clock),
        .reset     (reset),
        .lookup_pc (lookup_pc),
        .update    (u_update),
        .hit       (target_hit),
        .uncond    (target_uncond),
        .target    (target_pc)
    );

    //////////////////////////////
    // prediction
    //////////////////////////////

    assign predict_hit = target_hit;

    // no target means no redirect, whatever the counter says
    assign predict_taken = target_hit && (target_uncond || counter_taken);

    assign fall_through = lookup_pc + pc_t'(4);

    // next fetch address
    assign next_pc = predict_taken ? target_pc : fall_through;

endmodule

// File: dv/bp_props.sv
// prediction output checks bound into branch_predictor; silent while reset is high
`timescale 1ns/1ps

module bp_props
    import bp_pkg::*;
(
    input logic clock,
    input logic reset,
    input pc_t  lookup_pc,
    input logic predict_hit,
    input logic predict_taken,
    input pc_t  next_pc
);

    //////////////////////////////
    // output sanity
    //////////////////////////////

    // no x on the prediction once the tables are cleared
    known_outputs: assert property (@(posedge clock) disable iff (reset)
        !$isunknown({predict_hit, predict_taken, next_pc}))
        else $error("prediction outputs unknown after reset");

    // fall through on a not-taken prediction
    fall_through_pc: assert property (@(posedge clock) disable iff (reset)
        !predict_taken |-> (next_pc == lookup_pc + 32'd4))
        else $error("not-taken prediction with next_pc other than lookup_pc plus 4");

    // empty tables right after reset
    clear_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> (!predict_hit && !predict_taken))
        else $error("prediction not cleared by reset");

endmodule

// File: dv/bp_tb.sv
// self-checking testbench; word-aligned pcs only, outputs compared half a cycle after each drive
`timescale 1ns/1ps
`include "bp_macros.svh"

module bp_tb
    import bp_pkg::*;
();

    localparam int reset_cycles    = 2;
    // directed tests: 4 + 2 + 8 + 8 + 4 cycles
    localparam int directed_cycles = 26;
    localparam int random_cycles   = 400;
    localparam int timeout_cycles  = reset_cycles + directed_cycles + random_cycles + 50;
    localparam int ctr_depth       = 2 ** (`BP_INDEX_BITS + `BP_HIST_BITS);
    localparam int btb_depth       = 2 ** `BP_INDEX_BITS;

    logic clock = 1'b0;
    logic reset;
    pc_t  lookup_pc;
    logic update_valid;
    logic update_cond;
    pc_t  update_pc;
    logic update_taken;
    pc_t  update_target;
    logic predict_hit;
    logic predict_taken;
    pc_t  next_pc;

    // reference tables
    hist_t      hist_model [btb_depth];
    ctr_state_t ctr_model  [ctr_depth];
    logic       btb_valid  [btb_depth];
    logic       btb_uncond [btb_depth];
    tag_t       btb_tag    [btb_depth];
    pc_t        btb_target [btb_depth];

    // expected {hit, taken, next_pc} per driven lookup
    logic [33:0] expected_q [$];
    logic [33:0] expected_now;
    logic [31:0] lfsr_state  = 32'h45ac_d46c;
    int          error_count = 0;
    int          cycle_count = 0;

    always #5 clock = ~clock;

    branch_predictor dut (
        .clock         (clock),
        .reset         (reset),
        .lookup_pc     (lookup_pc),
        .update_valid  (update_valid),
        .update_cond   (update_cond),
        .update_pc     (update_pc),
        .update_taken  (update_taken),
        .update_target (update_target),
        .predict_hit   (predict_hit),
        .predict_taken (predict_taken),
        .next_pc       (next_pc)
    );

    bind branch_predictor bp_props u_props (
        .clock         (clock),
        .reset         (reset),
        .lookup_pc     (lookup_pc),
        .predict_hit   (predict_hit),
        .predict_taken (predict_taken),
        .next_pc       (next_pc)
    );

    //////////////////////////////
    // reference model
    //////////////////////////////

    function automatic ctr_state_t next_counter(input ctr_state_t state, input logic taken);
        case (state)
            nt_strong: return taken ? nt_weak : nt_strong;
            nt_weak:   return taken ? t_strong : nt_strong;
            t_weak:    return taken ? t_strong : nt_strong;
            default:   return taken ? t_strong : t_weak;
        endcase
    endfunction

    function automatic logic [33:0] ref_predict(input pc_t pc);
        index_t     idx;
        ctr_state_t state;
        logic       hit;
        logic       taken;
        idx   = pc[2 +: `BP_INDEX_BITS];
        state = ctr_model[{idx, hist_model[idx]}];
        hit   = btb_valid[idx] && (btb_tag[idx] == pc[2+`BP_INDEX_BITS +: `BP_TAG_BITS]);
        taken = hit && (btb_uncond[idx] || state == t_weak || state == t_strong);
        return {hit, taken, taken ? btb_target[idx] : pc + 32'd4};
    endfunction

    // counter trains under the old history, then the history shifts
    task automatic model_update(input logic cond, input pc_t pc, input logic taken,
                                input pc_t target);
        index_t idx;
        hist_t  hist;
        idx  = pc[2 +: `BP_INDEX_BITS];
        hist = hist_model[idx];
        if (cond) begin
            ctr_model[{idx, hist}] = next_counter(ctr_model[{idx, hist}], taken);
            hist_model[idx]        = {hist[`BP_HIST_BITS-2:0], taken};
        end
        btb_valid[idx]  = 1'b1;
        btb_uncond[idx] = !cond;
        btb_tag[idx]    = pc[2+`BP_INDEX_BITS +: `BP_TAG_BITS];
        btb_target[idx] = {target[31:2], 2'b00};
    endtask

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    // lookup sees the model before this cycle's update
    task automatic drive(input pc_t pc, input logic valid, input logic cond, input pc_t upc,
                         input logic taken, input pc_t target);
        @(posedge clock);
        lookup_pc     <= pc;
        update_valid  <= valid;
        update_cond   <= cond;
        update_pc     <= upc;
        update_taken  <= taken;
        update_target <= target;
        expected_q.push_back(ref_predict(pc));
        if (valid) begin
            model_update(cond, upc, taken, target);
        end
    endtask

    task automatic lookup(input pc_t pc);
        drive(pc, 1'b0, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic check(input string what, input pc_t got, input pc_t expected);
        if (got !== expected) begin
            error_count++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            $display("*** FAILED ***");
            $fatal(1, "stopping at first error");
        end
    endtask

    //////////////////////////////
    // compare and timeout
    //////////////////////////////

    // outputs settle between edges
    always @(negedge clock) begin
        if (expected_q.size() > 0) begin
            expected_now = expected_q.pop_front();
            check("predict_hit", {31'd0, predict_hit}, {31'd0, expected_now[33]});
            check("predict_taken", {31'd0, predict_taken}, {31'd0, expected_now[32]});
            check("next_pc", next_pc, expected_now[31:0]);
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("*** FAILED ***");
            $fatal(1, "run hung");
        end
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        logic [31:0] r;
        pc_t         lpc;
        pc_t         upc;
        reset         = 1'b1;
        lookup_pc     = '0;
        update_valid  = 1'b0;
        update_cond   = 1'b0;
        update_pc     = '0;
        update_taken  = 1'b0;
        update_target = '0;
        for (int i = 0; i < btb_depth; i++) begin
            hist_model[i] = '0;
            btb_valid[i]  = 1'b0;
            btb_uncond[i] = 1'b0;
            btb_tag[i]    = '0;
            btb_target[i] = '0;
        end
        for (int i = 0; i < ctr_depth; i++) begin
            ctr_model[i] = nt_weak;
        end
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;

        // empty tables miss everywhere
        lookup(32'h0000_0000);
        lookup(32'h0000_0100);
        lookup(32'h0000_0204);
        lookup(32'hffff_fffc);
        // unconditional branch, then hit on the next lookup
        drive(32'h0000_0204, 1'b1, 1'b0, 32'h0000_0204, 1'b1, 32'h0000_0400);
        lookup(32'h0000_0204);
        // conditional training up, then back down
        for (int i = 0; i < 3; i++) begin
            drive(32'h0000_0308, 1'b1, 1'b1, 32'h0000_0308, 1'b1, 32'h0000_0380);
        end
        for (int i = 0; i < 4; i++) begin
            drive(32'h0000_0308, 1'b1, 1'b1, 32'h0000_0308, 1'b0, 32'h0000_0380);
        end
        lookup(32'h0000_0308);
        // alternating branch walks through the history values
        for (int i = 0; i < 8; i++) begin
            drive(32'h0000_050c, 1'b1, 1'b1, 32'h0000_050c, !i[0], 32'h0000_0a00);
        end
        // same index as 0x204 with another tag
        lookup(32'h0000_0604);
        drive(32'h0000_0704, 1'b1, 1'b0, 32'h0000_0704, 1'b1, 32'h0000_0900);
        lookup(32'h0000_0704);
        lookup(32'h0000_0204);

        // random mix over 64 pcs
        for (int n = 0; n < random_cycles; n++) begin
            take_bits(6, r);
            lpc = 32'h0000_1000 | {24'd0, r[5:0], 2'b00};
            take_bits(6, r);
            upc = 32'h0000_1000 | {24'd0, r[5:0], 2'b00};
            take_bits(15, r);
            drive(lpc, r[14], r[13], upc, r[12], 32'h0000_8000 | {18'd0, r[11:0], 2'b00});
        end
        @(posedge clock);
        update_valid <= 1'b0;
        while (expected_q.size() != 0) begin
            @(posedge clock);
        end

        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+logic
logic/bp_pkg.sv
logic/bp_update_if.sv
logic/pred_table.sv
logic/history_unit.sv
logic/counter_unit.sv
logic/target_unit.sv
logic/branch_predictor.sv
dv/bp_props.sv
dv/bp_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run, then decide from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f vlog.f --top-module bp_tb -o bp_sim \
    || { echo "build failed"; exit 1; }

# a crash or assertion stop without a verdict still counts as a failure
./obj_dir/bp_sim > sim.log 2>&1 || echo "*** FAILED ***" >> sim.log
cat sim.log

grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "simulation failed"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "no verdict in log"; exit 1; }
echo "simulation passed"
